// ==== pulse_tx_cfg_pkg.sv ====
// Register map for word-aligned accesses only; address bits 1:0 are ignored by the decoder
`default_nettype none

package pulse_tx_cfg_pkg;

    // Register word offsets on address bits 4:2, address bit 5 low
    localparam logic [2:0] ADDR_CTRL  = 3'd0;
    localparam logic [2:0] ADDR_PROG  = 3'd1;
    localparam logic [2:0] ADDR_DUR   = 3'd2;
    localparam logic [2:0] ADDR_PRESC = 3'd3;

    // Program memory, address bit 5 high, word on bits 4:2
    localparam int NUM_PROG_WORDS = 8;

    localparam int DUR_W   = 8;
    localparam int PRESC_W = 4;
    localparam int IRQ_W   = 3;

    // Interrupt sources, symbol_done in bit 0
    typedef struct packed {
        logic prog_end;
        logic loop;
        logic symbol_done;
    } irq_vec_t;

    // 1-bit mode symbol maps, each entry coded as {level, alt}
    typedef struct packed {
        logic [1:0] high_1;
        logic [1:0] high_0;
        logic [1:0] low_1;
        logic [1:0] low_0;
    } sym_map_t;

    // Control word layout
    typedef struct packed {
        logic [5:0] rsvd_31_26;
        sym_map_t   maps;
        logic       use_2bpe;
        logic [1:0] rsvd_16_15;
        logic       invert;
        logic       idle_level;
        logic       loop_forever;
        logic       rsvd_11;
        irq_vec_t   irq_en;
        logic [1:0] rsvd_7_6;
        logic       stop;
        logic       running;
        logic       rsvd_3;
        irq_vec_t   irq_status;
    } ctrl_reg_t;

    typedef struct packed {
        logic [7:0] loop_count;
        logic [7:0] loopback_index;
        logic [7:0] end_index;
        logic [7:0] start_index;
    } prog_reg_t;

    typedef struct packed {
        logic [DUR_W-1:0] high_b;
        logic [DUR_W-1:0] high_a;
        logic [DUR_W-1:0] low_b;
        logic [DUR_W-1:0] low_a;
    } dur_reg_t;

    // Configuration seen by the execute and result stages
    typedef struct packed {
        prog_reg_t          prog;
        dur_reg_t           dur;
        logic [PRESC_W-1:0] prescaler;
        sym_map_t           maps;
        logic               use_2bpe;
        logic               loop_forever;
        logic               idle_level;
        logic               invert;
    } tx_cfg_t;

endpackage

`default_nettype wire

// ==== pulse_tx_sym_pkg.sv ====
// Program position is 8 bits, so the program always wraps over the full eight-word memory
`default_nettype none

package pulse_tx_sym_pkg;

    // Bits 7:5 pick the word, bits 4:0 the bit in that word
    typedef logic [7:0] pc_t;

    // Level selects low or high durations, alt picks duration a or b
    typedef struct packed {
        logic level;
        logic alt;
    } symbol_t;

    // One program word, read as symbols in 2-bit mode
    // and as single elements in 1-bit mode
    typedef union packed {
        symbol_t [15:0] sym;
        logic    [31:0] elem;
    } prog_word_u;

    // Symbol in flight, half marks the second symbol of a 1-bit element
    typedef struct packed {
        pc_t  pc;
        logic half;
    } sym_pos_t;

endpackage

`default_nettype wire

// ==== pulse_tx_regs.sv ====
// Program words take 32-bit writes only; read data ignores the address and is always ready
`timescale 1ns/100ps
`default_nettype none

module pulse_tx_regs import pulse_tx_cfg_pkg::*, pulse_tx_sym_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [5:0]                        address,
    input  logic [31:0]                       data_in,
    input  logic [1:0]                        data_write_n,
    input  irq_vec_t                          events,
    input  logic                              prog_done,
    input  pc_t                               pc,
    input  logic [7:0]                        loop_count_now,
    output logic [31:0]                       data_out,
    output logic                              data_ready,
    output tx_cfg_t                           cfg,
    output logic                              running,
    output logic                              mem_we,
    output logic [$clog2(NUM_PROG_WORDS)-1:0] mem_idx,
    output logic [31:0]                       mem_wdata,
    output logic                              irq
);

    ctrl_reg_t          ctrl_q;
    prog_reg_t          prog_q;
    dur_reg_t           dur_q;
    logic [PRESC_W-1:0] presc_q;
    ctrl_reg_t          ctrl_in;
    irq_vec_t           irq_set;
    irq_vec_t           irq_clr;
    logic               wr_any;
    logic               wr32;
    logic               reg_wr;

    // 00 is an 8-bit write, 10 a 32-bit write
    assign wr_any = (data_write_n == 2'b00) || (data_write_n == 2'b10);
    assign wr32   = (data_write_n == 2'b10);
    assign reg_wr = wr_any && !address[5];

    assign ctrl_in = ctrl_reg_t'(data_in);
    assign irq_clr = irq_vec_t'(data_in[IRQ_W-1:0]);
    // Only enabled events reach the status bits
    assign irq_set = events & ctrl_q.irq_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q  <= '0;
            prog_q  <= '0;
            dur_q   <= '0;
            presc_q <= '0;
        end else begin
            // Sticky status, program end drops running
            ctrl_q.irq_status <= ctrl_q.irq_status | irq_set;
            ctrl_q.running    <= ctrl_q.running & ~prog_done;
            if (reg_wr) begin
                case (address[4:2])
                    ADDR_CTRL: begin
                        // Write 1 to clear, new events still land
                        ctrl_q.irq_status <= (ctrl_q.irq_status & ~irq_clr) | irq_set;
                        // Stop wins over start
                        if (ctrl_in.stop) begin
                            ctrl_q.running <= 1'b0;
                        end else if (ctrl_in.running) begin
                            ctrl_q.running <= 1'b1;
                        end
                        // Upper control fields need the full word
                        if (wr32) begin
                            ctrl_q.irq_en       <= ctrl_in.irq_en;
                            ctrl_q.loop_forever <= ctrl_in.loop_forever;
                            ctrl_q.idle_level   <= ctrl_in.idle_level;
                            ctrl_q.invert       <= ctrl_in.invert;
                            ctrl_q.use_2bpe     <= ctrl_in.use_2bpe;
                            ctrl_q.maps         <= ctrl_in.maps;
                        end
                    end
                    ADDR_PROG:  prog_q  <= prog_reg_t'(data_in);
                    ADDR_DUR:   dur_q   <= dur_reg_t'(data_in);
                    ADDR_PRESC: presc_q <= data_in[PRESC_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Program word write strobe, delayed one cycle with its data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_we <= 1'b0;
        end else begin
            mem_we <= address[5] && wr32;
        end
    end

    always_ff @(posedge clk) begin
        mem_idx   <= address[4:2];
        mem_wdata <= data_in;
    end

    always_comb begin
        cfg              = '0;
        cfg.prog         = prog_q;
        cfg.dur          = dur_q;
        cfg.prescaler    = presc_q;
        cfg.maps         = ctrl_q.maps;
        cfg.use_2bpe     = ctrl_q.use_2bpe;
        cfg.loop_forever = ctrl_q.loop_forever;
        cfg.idle_level   = ctrl_q.idle_level;
        cfg.invert       = ctrl_q.invert;
    end

    assign running = ctrl_q.running;
    assign irq     = |ctrl_q.irq_status;

    // Same readback for every address, running in bit 4 as in the control word
    assign data_out   = {8'h00, pc, loop_count_now, 3'b000, ctrl_q.running, 1'b0,
                         ctrl_q.irq_status};
    assign data_ready = 1'b1;

endmodule

`default_nettype wire

// ==== pulse_tx_symbol_fetch.sv ====
// Program memory has no reset, so words must be written before a start
`timescale 1ns/100ps
`default_nettype none

module pulse_tx_symbol_fetch import pulse_tx_cfg_pkg::*, pulse_tx_sym_pkg::*; (
    input  logic                              clk,
    input  logic                              mem_we,
    input  logic [$clog2(NUM_PROG_WORDS)-1:0] mem_idx,
    input  logic [31:0]                       mem_wdata,
    input  sym_pos_t                          pos,
    input  tx_cfg_t                           cfg,
    output logic                              level,
    output logic [DUR_W-1:0]                  duration
);

    prog_word_u mem [NUM_PROG_WORDS];
    prog_word_u word;
    symbol_t    sym;
    logic       elem;

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_idx] <= prog_word_u'(mem_wdata);
        end
    end

    // Word select from the top pc bits
    assign word = mem[pos.pc[7:5]];
    assign elem = word.elem[pos.pc[4:0]];

    always_comb begin
        if (cfg.use_2bpe) begin
            // Even and odd pc share one symbol
            sym = word.sym[pos.pc[4:1]];
        end else if (elem) begin
            // High element, half picks map 0 or map 1
            sym = pos.half ? symbol_t'(cfg.maps.high_1) : symbol_t'(cfg.maps.high_0);
        end else begin
            sym = pos.half ? symbol_t'(cfg.maps.low_1) : symbol_t'(cfg.maps.low_0);
        end
    end

    assign level = sym.level;

    // Level and alt pick one of the four durations
    always_comb begin
        case ({sym.level, sym.alt})
            2'b00:   duration = cfg.dur.low_a;
            2'b01:   duration = cfg.dur.low_b;
            2'b10:   duration = cfg.dur.high_a;
            default: duration = cfg.dur.high_b;
        endcase
    end

endmodule

`default_nettype wire

// ==== pulse_tx_sequencer.sv ====
// Loop counter wraps below zero under loop_forever; readback pc shows the next symbol to load
`timescale 1ns/100ps
`default_nettype none

module pulse_tx_sequencer import pulse_tx_cfg_pkg::*, pulse_tx_sym_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       running,
    input  tx_cfg_t    cfg,
    input  logic       sym_done,
    output sym_pos_t   pos,
    output logic       load,
    output irq_vec_t   events,
    output logic       prog_done,
    output logic [7:0] loop_count_now
);

    sym_pos_t   cur_q;
    sym_pos_t   nxt;
    logic [7:0] loop_cnt_q;
    logic       run_q;
    logic       kick_q;
    logic       first;
    logic       step;
    logic       loop_hit;
    logic       end_hit;

    // First running cycle loads the positions
    assign first = running && !run_q;
    // Timer pulses only count once the first symbol is loaded
    assign step  = running && run_q && !kick_q && sym_done;

    // Position after the symbol in flight
    always_comb begin
        nxt      = cur_q;
        loop_hit = 1'b0;
        end_hit  = 1'b0;
        if (!cfg.use_2bpe && !cur_q.half) begin
            // Second symbol of the same element
            nxt.half = 1'b1;
        end else begin
            nxt.half = 1'b0;
            if (cur_q.pc == cfg.prog.end_index) begin
                if (loop_cnt_q == 8'd0 && !cfg.loop_forever) begin
                    end_hit = 1'b1;
                end else begin
                    loop_hit = 1'b1;
                    nxt.pc   = cfg.prog.loopback_index;
                end
            end else begin
                // Wraps at 256
                nxt.pc = cur_q.pc + (cfg.use_2bpe ? 8'd2 : 8'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q      <= 1'b0;
            kick_q     <= 1'b0;
            cur_q      <= '0;
            loop_cnt_q <= '0;
        end else begin
            run_q  <= running;
            kick_q <= first;
            if (first) begin
                cur_q.pc   <= cfg.prog.start_index;
                cur_q.half <= 1'b0;
                loop_cnt_q <= cfg.prog.loop_count;
            end else if (step && !end_hit) begin
                cur_q <= nxt;
                if (loop_hit) begin
                    loop_cnt_q <= loop_cnt_q - 8'd1;
                end
            end
        end
    end

    // Kick fetches the start symbol, later loads fetch the next one
    assign pos  = kick_q ? cur_q : nxt;
    assign load = (kick_q && running) || (step && !end_hit);

    assign events.symbol_done = step;
    assign events.loop        = step && loop_hit;
    assign events.prog_end    = step && end_hit;
    assign prog_done          = step && end_hit;

    assign loop_count_now = loop_cnt_q;

endmodule

`default_nettype wire

// ==== pulse_tx_timer.sv ====
// Each symbol lasts (duration+1)*(prescaler+1) cycles; a load in the last cycle chains without a gap
`timescale 1ns/100ps
`default_nettype none

module pulse_tx_timer import pulse_tx_cfg_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  logic [DUR_W-1:0]   duration,
    input  logic [PRESC_W-1:0] prescaler,
    output logic               sym_done
);

    logic [PRESC_W-1:0] presc_cnt_q;
    logic [DUR_W-1:0]   dur_cnt_q;
    logic               armed_q;

    // Last cycle of the symbol
    assign sym_done = armed_q && (presc_cnt_q == '0) && (dur_cnt_q == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc_cnt_q <= '0;
            dur_cnt_q   <= '0;
            armed_q     <= 1'b0;
        end else if (load) begin
            presc_cnt_q <= prescaler;
            dur_cnt_q   <= duration;
            armed_q     <= 1'b1;
        end else if (armed_q) begin
            if (presc_cnt_q != '0) begin
                presc_cnt_q <= presc_cnt_q - 1'b1;
            end else begin
                // One prescaler tick done
                presc_cnt_q <= prescaler;
                if (dur_cnt_q == '0) begin
                    armed_q <= 1'b0;
                end else begin
                    dur_cnt_q <= dur_cnt_q - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== pulse_tx_output.sv ====
// tx_out follows idle_level and invert combinationally, so config writes show at once when idle
`timescale 1ns/100ps
`default_nettype none

module pulse_tx_output import pulse_tx_cfg_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    running,
    input  logic    load,
    input  logic    level,
    input  tx_cfg_t cfg,
    output logic    tx_out,
    output logic    tx_active
);

    logic level_q;
    logic active_q;

    // Level of the symbol now on the line
    always_ff @(posedge clk) begin
        if (load) begin
            level_q <= level;
        end
    end

    // Active from the first load until running drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else begin
            active_q <= running && (active_q || load);
        end
    end

    // Falls with running at the same edge
    assign tx_active = running && active_q;

    assign tx_out = (tx_active ? level_q : cfg.idle_level) ^ cfg.invert;

endmodule

`default_nettype wire

// ==== pulse_tx_top.sv ====
// Bus writes land at the next edge and reads are always ready; no carrier output
`timescale 1ns/100ps
`default_nettype none

module pulse_tx_top import pulse_tx_cfg_pkg::*, pulse_tx_sym_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [5:0]  address,
    input  logic [31:0] data_in,
    input  logic [1:0]  data_write_n,
    output logic [31:0] data_out,
    output logic        data_ready,
    output logic        tx_out,
    output logic        tx_active,
    output logic        irq
);

    tx_cfg_t                           cfg;
    logic                              running;
    sym_pos_t                          pos;
    logic                              load;
    logic                              sym_done;
    logic                              prog_done;
    irq_vec_t                          events;
    logic [7:0]                        loop_count_now;
    logic                              level;
    logic [DUR_W-1:0]                  duration;
    logic                              mem_we;
    logic [$clog2(NUM_PROG_WORDS)-1:0] mem_idx;
    logic [31:0]                       mem_wdata;

    // Register decode and status
    pulse_tx_regs i_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .address        (address),
        .data_in        (data_in),
        .data_write_n   (data_write_n),
        .events         (events),
        .prog_done      (prog_done),
        .pc             (pos.pc),
        .loop_count_now (loop_count_now),
        .data_out       (data_out),
        .data_ready     (data_ready),
        .cfg            (cfg),
        .running        (running),
        .mem_we         (mem_we),
        .mem_idx        (mem_idx),
        .mem_wdata      (mem_wdata),
        .irq            (irq)
    );

    pulse_tx_symbol_fetch i_fetch (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_idx   (mem_idx),
        .mem_wdata (mem_wdata),
        .pos       (pos),
        .cfg       (cfg),
        .level     (level),
        .duration  (duration)
    );

    pulse_tx_sequencer i_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .running        (running),
        .cfg            (cfg),
        .sym_done       (sym_done),
        .pos            (pos),
        .load           (load),
        .events         (events),
        .prog_done      (prog_done),
        .loop_count_now (loop_count_now)
    );

    // Prescaler taken straight from the config
    pulse_tx_timer i_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .duration  (duration),
        .prescaler (cfg.prescaler),
        .sym_done  (sym_done)
    );

    pulse_tx_output i_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .running   (running),
        .load      (load),
        .level     (level),
        .cfg       (cfg),
        .tx_out    (tx_out),
        .tx_active (tx_active)
    );

endmodule

`default_nettype wire

// ==== tb_pulse_tx.sv ====
// Bus driven and tx_out sampled on falling edges; program words are random from a fixed seed
`timescale 1ns/100ps
`default_nettype none

module tb_pulse_tx import pulse_tx_cfg_pkg::*; ();

    // One table row, exp_status is {prog_end, loop, symbol_done}
    typedef struct packed {
        logic [8*8-1:0]   name;
        logic [31:0]      ctrl;
        prog_reg_t        prog;
        dur_reg_t         dur;
        logic [3:0]       presc;
        logic [7:0][31:0] words;
        logic             stop_run;
        logic [2:0]       exp_status;
        logic [2:0]       clear_mask;
    } test_t;

    logic        clk;
    logic        rst_n;
    logic [5:0]  address;
    logic [31:0] data_in;
    logic [1:0]  data_write_n;
    logic [31:0] data_out;
    logic        data_ready;
    logic        tx_out;
    logic        tx_active;
    logic        irq;

    test_t  tests [5];
    string  test_name;
    integer seed;
    int     cycles;
    int     cycle_limit;
    // Expected runs of tx_out, adjacent equal levels merged
    logic   exp_lvl [$];
    int     exp_len [$];
    logic   check_en;
    logic   in_run;
    logic   run_lvl;
    int     run_len;

    pulse_tx_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .data_in      (data_in),
        .data_write_n (data_write_n),
        .data_out     (data_out),
        .data_ready   (data_ready),
        .tx_out       (tx_out),
        .tx_active    (tx_active),
        .irq          (irq)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            fail_now($sformatf("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, exp, act));
        end
    endtask

    // Run limit from the expected stream length
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            fail_now($sformatf("TIMEOUT: run did not finish within %0d cycles", cycle_limit));
        end
    end

    // One write, held for a single cycle, 8-bit or 32-bit
    task automatic bus_write(input logic [5:0] addr, input logic [31:0] data, input logic wide);
        @(negedge clk);
        address      = addr;
        data_in      = data;
        data_write_n = wide ? 2'b10 : 2'b00;
        @(negedge clk);
        data_write_n = 2'b11;
    endtask

    // Maps packed as {high_1, high_0, low_1, low_0}, each symbol {level, alt}
    function automatic logic [31:0] make_ctrl(input logic [2:0] irq_en, input logic loop_on,
                                              input logic idle, input logic inv,
                                              input logic two_bit, input logic [7:0] maps);
        logic [31:0] w;
        w        = '0;
        w[10:8]  = irq_en;
        w[12]    = loop_on;
        w[13]    = idle;
        w[14]    = inv;
        w[17]    = two_bit;
        w[25:18] = maps;
        return w;
    endfunction

    // Reference model of the symbol stream, returns the total of all symbol lengths
    function automatic int expand_program(input test_t t);
        logic [7:0]  pc;
        logic        half;
        logic [7:0]  cnt;
        logic [31:0] w;
        logic [1:0]  s;
        logic [7:0]  d;
        logic        lvl;
        logic        two_bit;
        logic        finished;
        int          len;
        int          loops;
        int          total;
        two_bit  = t.ctrl[17];
        pc       = t.prog.start_index;
        half     = 1'b0;
        cnt      = t.prog.loop_count;
        loops    = 0;
        total    = 0;
        finished = 1'b0;
        exp_lvl.delete();
        exp_len.delete();
        while (!finished) begin
            w = t.words[pc[7:5]];
            if (two_bit) begin
                s = w[{pc[4:1], 1'b0} +: 2];
            end else if (w[pc[4:0]]) begin
                s = half ? t.ctrl[25:24] : t.ctrl[23:22];
            end else begin
                s = half ? t.ctrl[21:20] : t.ctrl[19:18];
            end
            case (s)
                2'b00:   d = t.dur.low_a;
                2'b01:   d = t.dur.low_b;
                2'b10:   d = t.dur.high_a;
                default: d = t.dur.high_b;
            endcase
            len   = (int'(d) + 1) * (int'(t.presc) + 1);
            lvl   = s[1] ^ t.ctrl[14];
            total = total + len;
            if (exp_lvl.size() > 0 && exp_lvl[exp_lvl.size()-1] == lvl) begin
                exp_len[exp_len.size()-1] = exp_len[exp_len.size()-1] + len;
            end else begin
                exp_lvl.push_back(lvl);
                exp_len.push_back(len);
            end
            if (!two_bit && !half) begin
                half = 1'b1;
            end else begin
                half = 1'b0;
                if (pc == t.prog.end_index) begin
                    // Endless loops are cut after two extra passes
                    if (t.ctrl[12] ? (loops >= 2) : (cnt == 8'd0)) begin
                        finished = 1'b1;
                    end else begin
                        pc    = t.prog.loopback_index;
                        cnt   = cnt - 8'd1;
                        loops = loops + 1;
                    end
                end else begin
                    pc = pc + (two_bit ? 8'd2 : 8'd1);
                end
            end
        end
        return total;
    endfunction

    task automatic fill_table();
        tests[0]      = '0;
        tests[0].name = "2bpe_run";
        tests[0].ctrl = make_ctrl(3'b111, 1'b0, 1'b0, 1'b0, 1'b1, 8'h00);
        // Count, loopback, end, start; crosses from word 0 into word 1
        tests[0].prog = {8'd0, 8'h1c, 8'h2a, 8'h1c};
        tests[0].dur  = {8'd7, 8'd3, 8'd5, 8'd2};
        tests[0].presc      = 4'd1;
        tests[0].exp_status = 3'b101;
        tests[0].clear_mask = 3'b001;
        tests[1]      = '0;
        tests[1].name = "1bpe_map";
        // Idle high, only prog_end enabled
        tests[1].ctrl = make_ctrl(3'b100, 1'b0, 1'b1, 1'b0, 1'b0, {2'b01, 2'b11, 2'b00, 2'b10});
        tests[1].prog = {8'd0, 8'h40, 8'h4b, 8'h40};
        tests[1].dur  = {8'd4, 8'd3, 8'd2, 8'd1};
        tests[1].presc      = 4'd0;
        tests[1].exp_status = 3'b100;
        tests[1].clear_mask = 3'b100;
        tests[2]      = '0;
        tests[2].name = "loopback";
        // Two extra passes over 0x62..0x66, prog_end masked
        tests[2].ctrl = make_ctrl(3'b011, 1'b0, 1'b0, 1'b0, 1'b1, 8'h00);
        tests[2].prog = {8'd2, 8'h62, 8'h66, 8'h60};
        tests[2].dur  = {8'd3, 8'd2, 8'd1, 8'd0};
        tests[2].presc      = 4'd2;
        tests[2].exp_status = 3'b011;
        tests[2].clear_mask = 3'b010;
        tests[3]      = '0;
        tests[3].name = "inverted";
        // pc wraps from 0xff to 0x00
        tests[3].ctrl = make_ctrl(3'b111, 1'b0, 1'b1, 1'b1, 1'b0, {2'b10, 2'b11, 2'b01, 2'b00});
        tests[3].prog = {8'd0, 8'hfe, 8'h01, 8'hfe};
        tests[3].dur  = {8'd6, 8'd5, 8'd4, 8'd3};
        tests[3].presc      = 4'd1;
        tests[3].exp_status = 3'b101;
        tests[3].clear_mask = 3'b111;
        tests[4]      = '0;
        tests[4].name = "stop_cmd";
        tests[4].ctrl = make_ctrl(3'b111, 1'b1, 1'b0, 1'b1, 1'b1, 8'h00);
        tests[4].prog = {8'd0, 8'h00, 8'h06, 8'h00};
        tests[4].dur  = {8'd6, 8'd5, 8'd4, 8'd3};
        tests[4].stop_run   = 1'b1;
        tests[4].exp_status = 3'b011;
        foreach (tests[i]) begin
            for (int w = 0; w < 8; w++) begin
                tests[i].words[w] = $random(seed);
            end
        end
    endtask

    // Compares one finished run of tx_out with the head of the expected list
    task automatic close_run();
        logic l;
        int   n;
        if (check_en) begin
            assert (exp_lvl.size() > 0) else begin
                fail_now($sformatf("%s: tx_out shows more runs than the program gives", test_name));
            end
            l = exp_lvl.pop_front();
            n = exp_len.pop_front();
            check_value("run level", l, run_lvl);
            check_value("run length", n, run_len);
        end
    endtask

    always @(negedge clk) begin
        if (tx_active) begin
            if (in_run && tx_out == run_lvl) begin
                run_len = run_len + 1;
            end else begin
                if (in_run) begin
                    close_run();
                end
                in_run  = 1'b1;
                run_lvl = tx_out;
                run_len = 1;
            end
        end else if (in_run) begin
            close_run();
            in_run = 1'b0;
        end
    end

    task automatic run_test(input test_t t);
        logic idle_out;
        test_name = $sformatf("%s", t.name);
        idle_out  = t.ctrl[13] ^ t.ctrl[14];
        bus_write(6'h00, 32'h0000_0007, 1'b0);
        check_value("status after clear", 0, data_out[2:0]);
        check_value("irq after clear", 0, irq);
        bus_write(6'h00, t.ctrl, 1'b1);
        bus_write(6'h04, t.prog, 1'b1);
        bus_write(6'h08, t.dur, 1'b1);
        bus_write(6'h0c, {28'h0, t.presc}, 1'b1);
        for (int w = 0; w < 8; w++) begin
            bus_write({1'b1, w[2:0], 2'b00}, t.words[w], 1'b1);
        end
        void'(expand_program(t));
        check_en = !t.stop_run;
        @(negedge clk);
        check_value("tx_out before start", idle_out, tx_out);
        check_value("tx_active before start", 0, tx_active);
        // Start with an 8-bit write, ones above bit 7 must not reach the config
        bus_write(6'h00, 32'hffff_ff10, 1'b0);
        check_value("running after start", 1, data_out[4]);
        check_value("tx_active 0 cycles after running", 0, tx_active);
        @(negedge clk);
        check_value("tx_active 1 cycle after running", 0, tx_active);
        @(negedge clk);
        check_value("tx_active 2 cycles after running", 1, tx_active);
        if (!t.stop_run) begin
            while (data_out[4] !== 1'b0) begin
                @(negedge clk);
            end
            check_value("tx_active after end", 0, tx_active);
            check_value("tx_out after end", idle_out, tx_out);
            @(negedge clk);
            check_value("runs not seen", 0, exp_lvl.size());
            // Loop counter readback sits in bits 15:8
            check_value("loop counter", 0, data_out[15:8]);
            // The last symbol leaves the position at the end index
            check_value("pc after end", t.prog.end_index, data_out[23:16]);
            check_value("status after end", t.exp_status, data_out[2:0]);
            check_value("irq after end", |t.exp_status, irq);
            bus_write(6'h00, {29'h0, t.clear_mask}, 1'b0);
            check_value("status after clear", t.exp_status & ~t.clear_mask, data_out[2:0]);
            check_value("irq after clear", |(t.exp_status & ~t.clear_mask), irq);
        end else begin
            // Let at least one loop pass before the stop
            while (data_out[1] !== 1'b1) begin
                @(negedge clk);
            end
            repeat (3) @(negedge clk);
            bus_write(6'h00, 32'h0000_0020, 1'b0);
            check_value("running after stop", 0, data_out[4]);
            check_value("tx_active after stop", 0, tx_active);
            check_value("tx_out after stop", idle_out, tx_out);
            repeat (4) @(negedge clk);
            check_value("status after stop", t.exp_status, data_out[2:0]);
            check_value("tx_active later", 0, tx_active);
        end
    endtask

    initial begin
        int total;
        seed         = 32'h1c94;
        rst_n        = 1'b0;
        address      = '0;
        data_in      = '0;
        data_write_n = 2'b11;
        check_en     = 1'b0;
        in_run       = 1'b0;
        run_lvl      = 1'b0;
        run_len      = 0;
        cycles       = 0;
        test_name    = "reset";
        fill_table();
        total = 0;
        foreach (tests[i]) begin
            total = total + expand_program(tests[i]);
        end
        cycle_limit = 2 * total + 200;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("tx_out", 0, tx_out);
        check_value("tx_active", 0, tx_active);
        check_value("status and running", 0, data_out[4:0]);
        check_value("irq", 0, irq);
        check_value("data_ready", 1, data_ready);
        foreach (tests[i]) begin
            run_test(tests[i]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pulse_tx.f ====
pulse_tx_cfg_pkg.sv
pulse_tx_sym_pkg.sv
pulse_tx_regs.sv
pulse_tx_symbol_fetch.sv
pulse_tx_sequencer.sv
pulse_tx_timer.sv
pulse_tx_output.sv
pulse_tx_top.sv
tb_pulse_tx.sv

// ==== Bender.yml ====
package:
  name: pulse_tx

sources:
  - pulse_tx_cfg_pkg.sv
  - pulse_tx_sym_pkg.sv
  - pulse_tx_regs.sv
  - pulse_tx_symbol_fetch.sv
  - pulse_tx_sequencer.sv
  - pulse_tx_timer.sv
  - pulse_tx_output.sv
  - pulse_tx_top.sv
  - target: test
    files:
      - tb_pulse_tx.sv
